// File: src/xgmii_pkg.sv
// ----------------------------------------------------------
// XGMII definitions shared by the transmit path
//   word and lane widths
//   control characters /I/ /S/ /T/ /E/
//   idle and start (preamble) words with their control masks
// ----------------------------------------------------------

package xgmii_pkg;

    // ------------------------------------------------------
    // bus widths
    // ------------------------------------------------------
    localparam int DATA_W = 64;
    localparam int LANES  = DATA_W / 8;

    // ------------------------------------------------------
    // control characters, one byte each
    // ------------------------------------------------------
    localparam logic [7:0] XGMII_IDLE  = 8'h07;
    localparam logic [7:0] XGMII_START = 8'hFB;
    localparam logic [7:0] XGMII_TERM  = 8'hFD;
    localparam logic [7:0] XGMII_ERROR = 8'hFE;

    // ------------------------------------------------------
    // full words
    // ------------------------------------------------------
    // /S/ in lane 0, six preamble bytes, SFD in lane 7
    localparam logic [DATA_W-1:0] PREAMBLE_WORD = 64'hD555_5555_5555_55FB;
    localparam logic [LANES-1:0]  PREAMBLE_CTRL = 8'h01;

    // all lanes idle
    localparam logic [DATA_W-1:0] IDLE_WORD = {LANES{XGMII_IDLE}};
    localparam logic [LANES-1:0]  IDLE_CTRL = {LANES{1'b1}};

endpackage

// File: src/tx_pkg.sv
// ----------------------------------------------------------
// Transmit framer definitions
//   framer FSM state encoding
//   IEEE 802.3 CRC-32 polynomial and preset
// ----------------------------------------------------------

package tx_pkg;

    // ------------------------------------------------------
    // framer states
    // ------------------------------------------------------
    // IDLE        waiting for the first beat, idles on the bus
    // DATA        one word behind the input, tail on the last word
    // TAIL_SPLIT  leftover FCS bytes plus /T/
    // TERM_ONLY   /T/ in lane 0, rest idle
    // GAP         mandatory full idle word before the next start
    typedef enum logic [2:0] {
        IDLE,
        DATA,
        TAIL_SPLIT,
        TERM_ONLY,
        GAP
    } tx_state_e;

    // ------------------------------------------------------
    // CRC-32
    // ------------------------------------------------------
    // reflected form, so bit 0 of each byte is processed first
    localparam logic [31:0] CRC_POLY   = 32'hEDB8_8320;
    localparam logic [31:0] CRC_PRESET = 32'hFFFF_FFFF;

endpackage

// File: src/tx_crc32.sv
// ----------------------------------------------------------
// Running CRC-32 for the transmit path
//   byte-wise update chain across all eight lanes
//   final FCS picked by the valid byte count of the last beat
// ----------------------------------------------------------

`timescale 1ns/10ps

module tx_crc32 (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          beat_i,
    input  logic                          first_i,
    input  logic                          last_i,
    input  logic [xgmii_pkg::DATA_W-1:0]  data_i,
    input  logic [xgmii_pkg::LANES-1:0]   keep_i,
    output logic [31:0]                   fcs_o
);

    logic [31:0] crc_q;
    logic [31:0] fcs_q;
    logic [31:0] seed;
    logic [31:0] chain [0:xgmii_pkg::LANES];
    logic [3:0]  nbytes;

    // one byte through the reflected polynomial
    function automatic logic [31:0] crc_byte(input logic [31:0] crc_in,
                                             input logic [7:0]  data_byte);
        logic [31:0] c;
        c = crc_in ^ {24'd0, data_byte};
        for (int b = 0; b < 8; b++) begin
            if (c[0]) begin
                c = (c >> 1) ^ tx_pkg::CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    // a new frame restarts from the preset
    assign seed = first_i ? tx_pkg::CRC_PRESET : crc_q;

    // ----------------------------------------------------------
    // unrolled chain, chain[k] holds the CRC after k bytes
    // ----------------------------------------------------------
    always_comb begin
        chain[0] = seed;
        for (int i = 0; i < xgmii_pkg::LANES; i++) begin
            chain[i+1] = crc_byte(chain[i], data_i[8*i +: 8]);
        end
    end

    // keep is contiguous from lane 0, so the count is the length
    always_comb begin
        nbytes = 4'd0;
        for (int i = 0; i < xgmii_pkg::LANES; i++) begin
            if (keep_i[i]) begin
                nbytes = nbytes + 4'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            crc_q <= tx_pkg::CRC_PRESET;
        end else if (beat_i) begin
            crc_q <= chain[xgmii_pkg::LANES];
        end
    end

    // reflected register already holds the first byte to send in [7:0]
    always_ff @(posedge clk) begin
        if (beat_i && last_i) begin
            fcs_q <= ~chain[nbytes];
        end
    end

    assign fcs_o = fcs_q;

endmodule

// File: src/tx_framer.sv
// ----------------------------------------------------------
// Transmit framer, AXI-Stream beats onto XGMII words
//   lane 0 start with the preamble word
//   one word delay so the FCS can follow the last data byte
//   /T/ placement, error abort and the minimum idle gap
// ----------------------------------------------------------

`timescale 1ns/10ps

module tx_framer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          tvalid_i,
    input  logic                          tlast_i,
    input  logic                          tuser_i,
    input  logic [xgmii_pkg::DATA_W-1:0]  tdata_i,
    input  logic [xgmii_pkg::LANES-1:0]   tkeep_i,
    input  logic [31:0]                   fcs_i,
    output logic                          tready_o,
    output logic                          beat_o,
    output logic                          first_o,
    output logic                          last_o,
    output logic [xgmii_pkg::DATA_W-1:0]  xgmii_d_o,
    output logic [xgmii_pkg::LANES-1:0]   xgmii_c_o,
    output logic                          good_o,
    output logic                          bad_o
);

    localparam int W = xgmii_pkg::DATA_W;
    localparam int L = xgmii_pkg::LANES;

    tx_pkg::tx_state_e state_q;

    logic           tready_q;
    logic           last_q;
    logic           user_q;
    logic           good_q;
    logic           bad_q;
    logic [W-1:0]   xgmii_d_q;
    logic [L-1:0]   xgmii_c_q;

    // one word delay on the payload
    logic [W-1:0]   dly_data;
    logic [L-1:0]   dly_keep;

    logic           beat;
    logic [3:0]     nbytes;
    logic [2*W-1:0] tail_d;
    logic [2*L-1:0] tail_c;

    assign beat = tvalid_i & tready_q;

    // ----------------------------------------------------------
    // tail assembly
    // ----------------------------------------------------------
    always_comb begin
        nbytes = 4'd0;
        for (int i = 0; i < L; i++) begin
            if (dly_keep[i]) begin
                nbytes = nbytes + 4'd1;
            end
        end
    end

    // data, 4 FCS bytes and /T/ laid out over two words, idles elsewhere
    always_comb begin
        tail_d = {2{xgmii_pkg::IDLE_WORD}};
        tail_c = '1;
        for (int i = 0; i < L; i++) begin
            if (i < nbytes) begin
                tail_d[8*i +: 8] = dly_data[8*i +: 8];
                tail_c[i]        = 1'b0;
            end
        end
        for (int j = 0; j < 4; j++) begin
            tail_d[8*(nbytes+j) +: 8] = fcs_i[8*j +: 8];
            tail_c[nbytes+j]          = 1'b0;
        end
        tail_d[8*(nbytes+4) +: 8] = xgmii_pkg::XGMII_TERM;
    end

    // ----------------------------------------------------------
    // FSM
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= tx_pkg::GAP;
            tready_q  <= 1'b0;
            last_q    <= 1'b0;
            user_q    <= 1'b0;
            good_q    <= 1'b0;
            bad_q     <= 1'b0;
            xgmii_d_q <= xgmii_pkg::IDLE_WORD;
            xgmii_c_q <= xgmii_pkg::IDLE_CTRL;
        end else begin
            good_q <= 1'b0;
            bad_q  <= 1'b0;
            case (state_q)
                tx_pkg::IDLE: begin
                    xgmii_d_q <= xgmii_pkg::IDLE_WORD;
                    xgmii_c_q <= xgmii_pkg::IDLE_CTRL;
                    if (beat) begin
                        xgmii_d_q <= xgmii_pkg::PREAMBLE_WORD;
                        xgmii_c_q <= xgmii_pkg::PREAMBLE_CTRL;
                        last_q    <= tlast_i;
                        user_q    <= tuser_i;
                        tready_q  <= ~tlast_i;
                        state_q   <= tx_pkg::DATA;
                    end
                end

                tx_pkg::DATA: begin
                    if (last_q) begin
                        if (user_q) begin
                            // /E/ lane 0, /T/ lane 7, beat data in between
                            xgmii_d_q <= {xgmii_pkg::XGMII_TERM, dly_data[W-9:8],
                                          xgmii_pkg::XGMII_ERROR};
                            xgmii_c_q <= {1'b1, {(L-2){1'b0}}, 1'b1};
                            bad_q     <= 1'b1;
                            state_q   <= tx_pkg::GAP;
                        end else begin
                            xgmii_d_q <= tail_d[W-1:0];
                            xgmii_c_q <= tail_c[L-1:0];
                            if (nbytes <= 4'd3) begin
                                good_q  <= 1'b1;
                                state_q <= tx_pkg::GAP;
                            end else if (nbytes == 4'd4) begin
                                state_q <= tx_pkg::TERM_ONLY;
                            end else begin
                                state_q <= tx_pkg::TAIL_SPLIT;
                            end
                        end
                    end else if (beat) begin
                        // gaps inside a frame are not supported, words only move on a beat
                        xgmii_d_q <= dly_data;
                        xgmii_c_q <= '0;
                        last_q    <= tlast_i;
                        user_q    <= tuser_i;
                        tready_q  <= ~tlast_i;
                    end
                end

                tx_pkg::TAIL_SPLIT: begin
                    xgmii_d_q <= tail_d[2*W-1:W];
                    xgmii_c_q <= tail_c[2*L-1:L];
                    good_q    <= 1'b1;
                    state_q   <= tx_pkg::GAP;
                end

                tx_pkg::TERM_ONLY: begin
                    xgmii_d_q <= {{(L-1){xgmii_pkg::XGMII_IDLE}}, xgmii_pkg::XGMII_TERM};
                    xgmii_c_q <= '1;
                    good_q    <= 1'b1;
                    state_q   <= tx_pkg::GAP;
                end

                tx_pkg::GAP: begin
                    // input reopens while the idle word is on the bus
                    xgmii_d_q <= xgmii_pkg::IDLE_WORD;
                    xgmii_c_q <= xgmii_pkg::IDLE_CTRL;
                    last_q    <= 1'b0;
                    user_q    <= 1'b0;
                    tready_q  <= 1'b1;
                    state_q   <= tx_pkg::IDLE;
                end

                default: begin
                    state_q <= tx_pkg::GAP;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (beat) begin
            dly_data <= tdata_i;
            dly_keep <= tkeep_i;
        end
    end

    assign tready_o  = tready_q;
    assign beat_o    = beat;
    assign first_o   = (state_q == tx_pkg::IDLE);
    assign last_o    = tlast_i;
    assign xgmii_d_o = xgmii_d_q;
    assign xgmii_c_o = xgmii_c_q;
    assign good_o    = good_q;
    assign bad_o     = bad_q;

endmodule

// File: src/tx_frame_counters.sv
// ----------------------------------------------------------
// Good and aborted frame counters
//   saturating, CNT_W bits each
// ----------------------------------------------------------

`timescale 1ns/10ps

module tx_frame_counters #(
    parameter int CNT_W = 32
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             good_i,
    input  logic             bad_i,
    output logic [CNT_W-1:0] good_frames_o,
    output logic [CNT_W-1:0] bad_frames_o
);

    // index 0 counts good frames, index 1 aborted ones
    logic [1:0]       inc;
    logic [CNT_W-1:0] cnt_q [2];

    assign inc = {bad_i, good_i};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                // hold at all ones
                if (inc[i] && (cnt_q[i] != {CNT_W{1'b1}})) begin
                    cnt_q[i] <= cnt_q[i] + CNT_W'(1);
                end
            end
        end
    end

    assign good_frames_o = cnt_q[0];
    assign bad_frames_o  = cnt_q[1];

endmodule

// File: src/axis_xgmii_tx.sv
// ----------------------------------------------------------
// 10G Ethernet MAC transmit, AXI-Stream to XGMII
//   framer, CRC-32 generator and frame counters
// ----------------------------------------------------------

`timescale 1ns/10ps

module axis_xgmii_tx #(
    parameter int CNT_W = 32
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [xgmii_pkg::DATA_W-1:0]  tdata_i,
    input  logic [xgmii_pkg::LANES-1:0]   tkeep_i,
    input  logic                          tvalid_i,
    input  logic                          tlast_i,
    input  logic                          tuser_i,
    output logic                          tready_o,
    output logic [xgmii_pkg::DATA_W-1:0]  xgmii_d_o,
    output logic [xgmii_pkg::LANES-1:0]   xgmii_c_o,
    output logic [CNT_W-1:0]              good_frames_o,
    output logic [CNT_W-1:0]              bad_frames_o
);

    logic        beat;
    logic        first;
    logic        last;
    logic [31:0] fcs;
    logic        good;
    logic        bad;

    tx_framer u_framer (
        .clk       (clk),
        .rst       (rst),
        .tvalid_i  (tvalid_i),
        .tlast_i   (tlast_i),
        .tuser_i   (tuser_i),
        .tdata_i   (tdata_i),
        .tkeep_i   (tkeep_i),
        .fcs_i     (fcs),
        .tready_o  (tready_o),
        .beat_o    (beat),
        .first_o   (first),
        .last_o    (last),
        .xgmii_d_o (xgmii_d_o),
        .xgmii_c_o (xgmii_c_o),
        .good_o    (good),
        .bad_o     (bad)
    );

    // data and keep come straight from the input, in step with beat
    tx_crc32 u_crc (
        .clk     (clk),
        .rst     (rst),
        .beat_i  (beat),
        .first_i (first),
        .last_i  (last),
        .data_i  (tdata_i),
        .keep_i  (tkeep_i),
        .fcs_o   (fcs)
    );

    tx_frame_counters #(
        .CNT_W (CNT_W)
    ) u_counters (
        .clk           (clk),
        .rst           (rst),
        .good_i        (good),
        .bad_i         (bad),
        .good_frames_o (good_frames_o),
        .bad_frames_o  (bad_frames_o)
    );

endmodule

// File: dv/tb_axis_xgmii_tx_sva.sv
// ----------------------------------------------------------
// Concurrent assertions on the transmit framer
//   no tvalid gap inside a frame, tready low after a last beat
//   idle after /T/, good and bad strobes exclusive
// ----------------------------------------------------------

`timescale 1ns/10ps

module tb_axis_xgmii_tx_sva (
    input logic                          clk,
    input logic                          rst,
    input logic                          tvalid_i,
    input logic                          tlast_i,
    input logic                          tready_i,
    input logic                          beat_i,
    input logic [xgmii_pkg::DATA_W-1:0]  xgmii_d_i,
    input logic [xgmii_pkg::LANES-1:0]   xgmii_c_i,
    input logic                          good_i,
    input logic                          bad_i
);

    logic term_word;

    // any lane carrying /T/ as a control character
    always_comb begin
        term_word = 1'b0;
        for (int i = 0; i < xgmii_pkg::LANES; i++) begin
            if (xgmii_c_i[i] && xgmii_d_i[8*i +: 8] == xgmii_pkg::XGMII_TERM) begin
                term_word = 1'b1;
            end
        end
    end

    valid_held_in_frame: assert property (@(posedge clk) disable iff (rst)
        beat_i && !tlast_i |=> tvalid_i)
        else $error("tvalid_i dropped inside a frame");

    ready_low_after_last: assert property (@(posedge clk) disable iff (rst)
        beat_i && tlast_i |=> !tready_i)
        else $error("tready_o still high after the last beat");

    ctrl_after_term: assert property (@(posedge clk) disable iff (rst)
        term_word |=> xgmii_c_i != '0)
        else $error("data word right after a terminate word");

    good_bad_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(good_i && bad_i))
        else $error("good and bad frame strobes high together");

endmodule

bind tx_framer tb_axis_xgmii_tx_sva u_sva (
    .clk       (clk),
    .rst       (rst),
    .tvalid_i  (tvalid_i),
    .tlast_i   (tlast_i),
    .tready_i  (tready_o),
    .beat_i    (beat_o),
    .xgmii_d_i (xgmii_d_o),
    .xgmii_c_i (xgmii_c_o),
    .good_i    (good_o),
    .bad_i     (bad_o)
);

// File: dv/tb_axis_xgmii_tx.sv
// ----------------------------------------------------------
// Testbench for the AXI-Stream to XGMII transmit path
//   LFSR driven clean and aborted frames
//   XGMII monitor checked against a CRC-32 reference model
//   one report line per frame, counter check at the end
// ----------------------------------------------------------

`timescale 1ns/10ps

module tb_axis_xgmii_tx;

    localparam int CNT_W = 16;
    localparam int W     = xgmii_pkg::DATA_W;
    localparam int L     = xgmii_pkg::LANES;
    localparam int LIMIT = 200;

    logic             clk;
    logic             rst;
    logic [W-1:0]     tdata_i;
    logic [L-1:0]     tkeep_i;
    logic             tvalid_i;
    logic             tlast_i;
    logic             tuser_i;
    logic             tready_o;
    logic [W-1:0]     xgmii_d_o;
    logic [L-1:0]     xgmii_c_o;
    logic [CNT_W-1:0] good_frames_o;
    logic [CNT_W-1:0] bad_frames_o;

    // sent payload bytes, then length and abort flag per frame, oldest first
    logic [7:0]  exp_q [$];
    int          len_q [$];
    bit          abort_q [$];
    logic [7:0]  rx_q [$];
    logic [31:0] lfsr;
    int          frames_sent;
    int          frames_done;
    int          tests;
    int          errors;
    int          model_good;
    int          model_bad;
    int          gap_words;
    bit          in_frame;
    bit          seen_end;

    axis_xgmii_tx #(
        .CNT_W (CNT_W)
    ) UUT (
        .clk           (clk),
        .rst           (rst),
        .tdata_i       (tdata_i),
        .tkeep_i       (tkeep_i),
        .tvalid_i      (tvalid_i),
        .tlast_i       (tlast_i),
        .tuser_i       (tuser_i),
        .tready_o      (tready_o),
        .xgmii_d_o     (xgmii_d_o),
        .xgmii_c_o     (xgmii_c_o),
        .good_frames_o (good_frames_o),
        .bad_frames_o  (bad_frames_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // reference CRC, one data bit at a time, lsb first
    function automatic logic [31:0] crc_update(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        logic        fb;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            fb = c[0] ^ b[i];
            c  = {1'b0, c[31:1]} ^ (fb ? tx_pkg::CRC_POLY : 32'd0);
        end
        return c;
    endfunction

    task automatic report_mismatch(input string name, input logic [71:0] exp_v,
                                   input logic [71:0] act_v);
        $display("ERR %s expected %0h actual %0h", name, exp_v, act_v);
        errors++;
    endtask

    task automatic report_problem(input string what);
        $display("error: %s", what);
        errors++;
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout: %s", what);
        $display("sim failed");
        $finish;
    endtask

    // ----------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------
    task automatic send_frame(input int len, input bit abort, input int gap);
        logic [W-1:0] d;
        logic [L-1:0] keep;
        logic [7:0]   b;
        int           nbeats;
        int           waited;
        nbeats = (len + 7) / 8;
        if (gap > 0) begin
            tvalid_i <= 1'b0;
            tlast_i  <= 1'b0;
            tuser_i  <= 1'b0;
            repeat (gap) @(posedge clk);
        end
        for (int k = 0; k < nbeats; k++) begin
            keep = '0;
            for (int i = 0; i < L; i++) begin
                b            = 8'(rand_bits(8));
                d[8*i +: 8]  = b;
                if (k * 8 + i < len) begin
                    keep[i] = 1'b1;
                    exp_q.push_back(b);
                end
            end
            tdata_i  <= d;
            tkeep_i  <= keep;
            tvalid_i <= 1'b1;
            tlast_i  <= (k == nbeats - 1);
            tuser_i  <= abort && (k == nbeats - 1);
            // the beat moves on the first rising edge with tready_o high
            waited = 0;
            @(negedge clk);
            while (!tready_o) begin
                waited++;
                if (waited > LIMIT) begin
                    stop_on_timeout("tready_o stayed low while a beat was waiting");
                end
                @(negedge clk);
            end
            @(posedge clk);
        end
        len_q.push_back(len);
        abort_q.push_back(abort);
        frames_sent++;
    endtask

    // ----------------------------------------------------------
    // monitor and frame check
    // ----------------------------------------------------------
    task automatic check_frame(input bit aborted);
        string       name;
        logic [7:0]  e [$];
        logic [31:0] fcs;
        logic [31:0] rx_fcs;
        int          len;
        int          nkeep;
        int          first_bad;
        int          errs_before;
        bit          ab;
        name        = $sformatf("frame_%0d", frames_done);
        errs_before = errors;
        if (len_q.size() == 0) begin
            report_problem("a frame came out on XGMII with none sent");
        end else begin
            len = len_q.pop_front();
            ab  = abort_q.pop_front();
            fcs = tx_pkg::CRC_PRESET;
            for (int k = 0; k < len; k++) begin
                e.push_back(exp_q.pop_front());
                fcs = crc_update(fcs, e[k]);
            end
            fcs = ~fcs;
            // an aborted frame keeps only the full words before its last beat
            nkeep = ab ? ((len + 7) / 8 - 1) * 8 : len;
            if (ab) begin
                model_bad++;
            end else begin
                model_good++;
            end
            if (ab != aborted) begin
                report_mismatch({name, "_abort"}, ab, aborted);
            end else if (rx_q.size() != (ab ? nkeep : nkeep + 4)) begin
                report_mismatch({name, "_length"}, ab ? nkeep : nkeep + 4, rx_q.size());
            end else begin
                first_bad = -1;
                for (int k = 0; k < nkeep; k++) begin
                    if (rx_q[k] != e[k] && first_bad < 0) begin
                        first_bad = k;
                    end
                end
                if (first_bad >= 0) begin
                    report_mismatch({name, "_data"}, e[first_bad], rx_q[first_bad]);
                end
                if (!ab) begin
                    rx_fcs = {rx_q[len+3], rx_q[len+2], rx_q[len+1], rx_q[len]};
                    if (rx_fcs != fcs) begin
                        report_mismatch({name, "_fcs"}, fcs, rx_fcs);
                    end
                end
            end
            $display("%s len %0d %s %s", name, len, ab ? "abort" : "clean",
                     (errors == errs_before) ? "ok" : "FAILED");
        end
        frames_done++;
        tests++;
        in_frame  = 1'b0;
        seen_end  = 1'b1;
        gap_words = 0;
    endtask

    task automatic watch_word(input logic [W-1:0] d, input logic [L-1:0] c);
        logic [7:0] b;
        bit         ended;
        ended = 1'b0;
        if (!in_frame) begin
            if (d == xgmii_pkg::PREAMBLE_WORD && c == xgmii_pkg::PREAMBLE_CTRL) begin
                if (seen_end && gap_words < 1) begin
                    report_problem("preamble came with no full idle word after the last frame");
                end
                in_frame = 1'b1;
                rx_q.delete();
            end else if (d == xgmii_pkg::IDLE_WORD && c == xgmii_pkg::IDLE_CTRL) begin
                gap_words++;
            end else begin
                report_mismatch("idle", {xgmii_pkg::IDLE_CTRL, xgmii_pkg::IDLE_WORD}, {c, d});
            end
        end else if (c[0] && d[7:0] == xgmii_pkg::XGMII_ERROR) begin
            if (c != 8'h81 || d[W-1 -: 8] != xgmii_pkg::XGMII_TERM) begin
                report_problem("abort word lacks /T/ in lane 7 or has wrong control bits");
            end
            check_frame(1'b1);
        end else begin
            for (int i = 0; i < L; i++) begin
                b = d[8*i +: 8];
                if (ended) begin
                    if (!c[i] || b != xgmii_pkg::XGMII_IDLE) begin
                        report_problem("a lane after /T/ is not idle");
                    end
                end else if (!c[i]) begin
                    rx_q.push_back(b);
                end else if (b == xgmii_pkg::XGMII_TERM) begin
                    ended = 1'b1;
                end else begin
                    report_problem("unexpected control character inside a frame");
                end
            end
            if (ended) begin
                check_frame(1'b0);
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            watch_word(xgmii_d_o, xgmii_c_o);
        end
    end

    // ----------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------
    initial begin
        int len;
        int gap;
        int waited;
        int errs_before;
        bit ab;
        rst         = 1'b1;
        tdata_i     = '0;
        tkeep_i     = '0;
        tvalid_i    = 1'b0;
        tlast_i     = 1'b0;
        tuser_i     = 1'b0;
        lfsr        = 32'he4ae;
        frames_sent = 0;
        frames_done = 0;
        tests       = 0;
        errors      = 0;
        model_good  = 0;
        model_bad   = 0;
        gap_words   = 0;
        in_frame    = 1'b0;
        seen_end    = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        errs_before = errors;
        if ({xgmii_c_o, xgmii_d_o} != {xgmii_pkg::IDLE_CTRL, xgmii_pkg::IDLE_WORD}) begin
            report_mismatch("reset_xgmii", {xgmii_pkg::IDLE_CTRL, xgmii_pkg::IDLE_WORD},
                            {xgmii_c_o, xgmii_d_o});
        end
        if (good_frames_o != '0) begin
            report_mismatch("reset_good_frames", 0, good_frames_o);
        end
        if (bad_frames_o != '0) begin
            report_mismatch("reset_bad_frames", 0, bad_frames_o);
        end
        if (tready_o) begin
            report_problem("tready_o high in the first cycle after reset");
        end
        $display("reset_state %s", (errors == errs_before) ? "ok" : "FAILED");
        tests++;
        @(posedge clk);

        // every final byte count, back to back
        for (int n = 1; n <= 16; n++) begin
            send_frame(n, 1'b0, 0);
        end
        send_frame(5, 1'b1, 0);
        send_frame(20, 1'b1, 1);
        for (int n = 0; n < 40; n++) begin
            len = 1 + int'(rand_bits(6) % 40);
            ab  = (rand_bits(3) == 32'd0);
            gap = int'(rand_bits(2));
            send_frame(len, ab, gap);
        end
        tvalid_i <= 1'b0;
        tlast_i  <= 1'b0;
        tuser_i  <= 1'b0;

        waited = 0;
        while (frames_done < frames_sent) begin
            @(posedge clk);
            waited++;
            if (waited > LIMIT) begin
                stop_on_timeout("frames still missing on XGMII after the last beat");
            end
        end
        // counters lag their strobe by one cycle
        repeat (2) @(posedge clk);
        @(negedge clk);
        errs_before = errors;
        if (good_frames_o != CNT_W'(model_good)) begin
            report_mismatch("good_frames", model_good, good_frames_o);
        end
        if (bad_frames_o != CNT_W'(model_bad)) begin
            report_mismatch("bad_frames", model_bad, bad_frames_o);
        end
        $display("frame_counts %s", (errors == errs_before) ? "ok" : "FAILED");
        tests++;

        $display("tests %0d, frames %0d, errors %0d", tests, frames_done, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: sim.f
src/xgmii_pkg.sv
src/tx_pkg.sv
src/tx_crc32.sv
src/tx_framer.sv
src/tx_frame_counters.sv
src/axis_xgmii_tx.sv
dv/tb_axis_xgmii_tx_sva.sv
dv/tb_axis_xgmii_tx.sv

// File: Makefile
# Verilator build and run of the AXI-Stream to XGMII transmit testbench

TOP := tb_axis_xgmii_tx
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG) || ! grep -q "sim passed" $(LOG); then \
		echo "test FAILED"; exit 1; \
	else \
		echo "test PASSED"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
